//--- bj_pkg.sv
// Card, hand and result types for one player and one house; aces always count 1, five cards max
package bj_pkg;

    // Slots per hand
    localparam int MAX_CARDS = 5;

    // Highest total that still counts as a live hand
    localparam int BUST_LIMIT = 21;

    // House stops drawing at or above this total
    localparam int HOUSE_STAND = 17;

    // Shuffle start value, low six bits get replaced by the seed
    localparam logic [15:0] LFSR_INIT = 16'hace1;

    // Rank 1..13, zero marks an empty slot
    typedef logic [3:0] card_t;

    // Hand total, five tens fit easily
    typedef logic [5:0] sum_t;

    typedef struct packed {
        card_t [MAX_CARDS-1:0] cards;
        logic [2:0]            count;
        sum_t                  sum;
    } hand_t;

    typedef struct packed {
        hand_t player;
        hand_t house;
    } table_t;

    typedef enum logic {
        SIDE_PLAYER,
        SIDE_HOUSE
    } side_e;

    typedef enum logic [1:0] {
        OUT_NONE,
        OUT_PLAYER_WIN,
        OUT_HOUSE_WIN,
        OUT_DRAW
    } outcome_e;

    // Jack, queen and king are worth 10
    function automatic sum_t card_points(card_t c);
        sum_t pts;
        if (c > 4'd10) begin
            pts = 6'd10;
        end else begin
            pts = sum_t'(c);
        end
        return pts;
    endfunction

endpackage

//--- card_deck.sv
// Ranks come straight from a 16-bit LFSR, so a rank may repeat more than four times per game
`timescale 1ns/10ps

module card_deck #(
    parameter int SHUFFLE_STEPS = 32
) (
    input  logic          clk,
    input  logic          rst,
    input  logic [5:0]    seed,
    input  logic          shuffle_start,
    input  logic          card_req,
    output logic          deck_ready,
    output logic          card_valid,
    output bj_pkg::card_t card
);

    localparam int STEP_W = $clog2(SHUFFLE_STEPS + 1);

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_SHUFFLE,
        MODE_DEAL
    } mode_e;

    mode_e             mode;
    logic [15:0]       lfsr;
    logic [15:0]       lfsr_next;
    logic [STEP_W-1:0] step_cnt;
    logic              rank_ok;

    // Taps 16, 14, 13 and 11 give the full 65535-state sequence
    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

    // Low nibble is a legal rank
    assign rank_ok = (lfsr_next[3:0] != 4'd0) && (lfsr_next[3:0] <= 4'd13);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode       <= MODE_IDLE;
            lfsr       <= bj_pkg::LFSR_INIT;
            step_cnt   <= '0;
            deck_ready <= 1'b1;
            card_valid <= 1'b0;
        end else begin
            card_valid <= 1'b0;
            case (mode)
                MODE_IDLE: begin
                    if (shuffle_start) begin
                        lfsr       <= {bj_pkg::LFSR_INIT[15:6], seed};
                        step_cnt   <= '0;
                        deck_ready <= 1'b0;
                        mode       <= MODE_SHUFFLE;
                    end else if (card_req) begin
                        deck_ready <= 1'b0;
                        mode       <= MODE_DEAL;
                    end
                end
                MODE_SHUFFLE: begin
                    lfsr     <= lfsr_next;
                    step_cnt <= step_cnt + 1'b1;
                    // Last step lands together with ready
                    if (step_cnt == STEP_W'(SHUFFLE_STEPS - 1)) begin
                        deck_ready <= 1'b1;
                        mode       <= MODE_IDLE;
                    end
                end
                MODE_DEAL: begin
                    // Keep stepping until the nibble is a rank
                    lfsr <= lfsr_next;
                    if (rank_ok) begin
                        card_valid <= 1'b1;
                        deck_ready <= 1'b1;
                        mode       <= MODE_IDLE;
                    end
                end
                default: begin
                    mode <= MODE_IDLE;
                end
            endcase
        end
    end

    // Dealt rank is held until the next one
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            card <= '0;
        end else if (mode == MODE_DEAL && rank_ok) begin
            card <= lfsr_next[3:0];
        end
    end

    // Skipped nibbles never leak out as cards
    assert property (@(posedge clk) disable iff (!rst)
        card_valid |-> (card >= 4'd1 && card <= 4'd13));

endmodule

//--- hand_store.sv
// Both hands clear together; a card sent to a full hand is dropped and the hand stays as it was
`timescale 1ns/10ps

module hand_store (
    input  logic           clk,
    input  logic           rst,
    input  logic           clear,
    input  logic           add_card,
    input  bj_pkg::side_e  side,
    input  bj_pkg::card_t  card,
    output bj_pkg::table_t table_state
);

    bj_pkg::hand_t player_hand;
    bj_pkg::hand_t house_hand;
    logic          side_full;

    // Card goes into the first empty slot, total grows by its points
    function automatic bj_pkg::hand_t add_to_hand(bj_pkg::hand_t h, bj_pkg::card_t c);
        bj_pkg::hand_t nh;
        nh = h;
        if (h.count < 3'(bj_pkg::MAX_CARDS)) begin
            nh.cards[h.count] = c;
            nh.count          = h.count + 3'd1;
            nh.sum            = h.sum + bj_pkg::card_points(c);
        end
        return nh;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            player_hand <= '0;
            house_hand  <= '0;
        end else if (clear) begin
            player_hand <= '0;
            house_hand  <= '0;
        end else if (add_card) begin
            if (side == bj_pkg::SIDE_PLAYER) begin
                player_hand <= add_to_hand(player_hand, card);
            end else begin
                house_hand <= add_to_hand(house_hand, card);
            end
        end
    end

    assign table_state = '{player: player_hand, house: house_hand};

    // Selected side already holds five cards
    assign side_full = (side == bj_pkg::SIDE_PLAYER) ?
                       (player_hand.count == 3'(bj_pkg::MAX_CARDS)) :
                       (house_hand.count == 3'(bj_pkg::MAX_CARDS));

    // Controller stands the player at five and the house rule stops at five
    assert property (@(posedge clk) disable iff (!rst)
        add_card |-> !side_full);

endmodule

//--- game_fsm.sv
// Buttons must be synchronous to clk and act on a rising edge; start only works from idle or done
`timescale 1ns/10ps

module game_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             hit,
    input  logic             stand,
    input  logic             deck_ready,
    input  logic             card_valid,
    input  bj_pkg::table_t   table_state,
    output logic             shuffle_start,
    output logic             card_req,
    output logic             add_card,
    output bj_pkg::side_e    side,
    output logic             clear,
    output logic             player_turn,
    output logic             game_done,
    output bj_pkg::outcome_e outcome
);

    typedef enum logic [2:0] {
        IDLE,
        SHUFFLE,
        REQUEST,
        WAIT_CARD,
        PLAYER_TURN,
        HOUSE_TURN,
        JUDGE,
        DONE
    } state_e;

    typedef struct packed {
        logic start;
        logic hit;
        logic stand;
    } btn_t;

    // Opening deal is player, house, player, house
    localparam logic [2:0] DEAL_LAST = 3'd3;
    localparam logic [2:0] DEAL_DONE = 3'd4;

    state_e       state;
    btn_t         btn_q;
    btn_t         btn_prev;
    btn_t         btn_rise;
    logic [2:0]   deal_cnt;
    bj_pkg::sum_t player_sum;
    bj_pkg::sum_t house_sum;
    logic         player_bust;
    logic         house_bust;
    logic         player_full;
    logic         house_draws;

    // Register stage, then edge detect
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            btn_q    <= '0;
            btn_prev <= '0;
        end else begin
            btn_q    <= '{start: start, hit: hit, stand: stand};
            btn_prev <= btn_q;
        end
    end

    assign btn_rise = btn_t'(btn_q & ~btn_prev);

    // Rule checks on the current table
    assign player_sum  = table_state.player.sum;
    assign house_sum   = table_state.house.sum;
    assign player_bust = player_sum > bj_pkg::sum_t'(bj_pkg::BUST_LIMIT);
    assign house_bust  = house_sum > bj_pkg::sum_t'(bj_pkg::BUST_LIMIT);
    assign player_full = table_state.player.count == 3'(bj_pkg::MAX_CARDS);
    assign house_draws = (house_sum < bj_pkg::sum_t'(bj_pkg::HOUSE_STAND)) &&
                         (table_state.house.count < 3'(bj_pkg::MAX_CARDS));

    // Dealt card lands in the hand store at the next edge
    assign add_card = (state == WAIT_CARD) && card_valid;

    // Only a live hand with room waits for the player
    assign player_turn = (state == PLAYER_TURN) && !player_bust && !player_full;
    assign game_done   = (state == DONE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state         <= IDLE;
            deal_cnt      <= '0;
            side          <= bj_pkg::SIDE_PLAYER;
            shuffle_start <= 1'b0;
            card_req      <= 1'b0;
            clear         <= 1'b0;
            outcome       <= bj_pkg::OUT_NONE;
        end else begin
            shuffle_start <= 1'b0;
            card_req      <= 1'b0;
            clear         <= 1'b0;
            case (state)
                IDLE, DONE: begin
                    if (btn_rise.start) begin
                        clear         <= 1'b1;
                        shuffle_start <= 1'b1;
                        deal_cnt      <= '0;
                        side          <= bj_pkg::SIDE_PLAYER;
                        outcome       <= bj_pkg::OUT_NONE;
                        state         <= SHUFFLE;
                    end
                end
                SHUFFLE: begin
                    // Ready is still high in the pulse cycle, so skip it
                    if (!shuffle_start && deck_ready) begin
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (deck_ready) begin
                        card_req <= 1'b1;
                        state    <= WAIT_CARD;
                    end
                end
                WAIT_CARD: begin
                    if (card_valid) begin
                        if (deal_cnt < DEAL_LAST) begin
                            deal_cnt <= deal_cnt + 3'd1;
                            side     <= (side == bj_pkg::SIDE_PLAYER) ?
                                        bj_pkg::SIDE_HOUSE : bj_pkg::SIDE_PLAYER;
                            state    <= REQUEST;
                        end else if (deal_cnt == DEAL_LAST) begin
                            deal_cnt <= DEAL_DONE;
                            state    <= PLAYER_TURN;
                        end else if (side == bj_pkg::SIDE_HOUSE) begin
                            state <= HOUSE_TURN;
                        end else begin
                            state <= PLAYER_TURN;
                        end
                    end
                end
                PLAYER_TURN: begin
                    if (player_bust) begin
                        state <= JUDGE;
                    end else if (player_full) begin
                        // Forced stand at five cards
                        state <= HOUSE_TURN;
                    end else if (btn_rise.hit) begin
                        side  <= bj_pkg::SIDE_PLAYER;
                        state <= REQUEST;
                    end else if (btn_rise.stand) begin
                        state <= HOUSE_TURN;
                    end
                end
                HOUSE_TURN: begin
                    if (house_draws) begin
                        side  <= bj_pkg::SIDE_HOUSE;
                        state <= REQUEST;
                    end else begin
                        state <= JUDGE;
                    end
                end
                JUDGE: begin
                    // Player bust wins for the house even if the house would bust too
                    if (player_bust) begin
                        outcome <= bj_pkg::OUT_HOUSE_WIN;
                    end else if (house_bust || player_sum > house_sum) begin
                        outcome <= bj_pkg::OUT_PLAYER_WIN;
                    end else if (house_sum > player_sum) begin
                        outcome <= bj_pkg::OUT_HOUSE_WIN;
                    end else begin
                        outcome <= bj_pkg::OUT_DRAW;
                    end
                    state <= DONE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Each request waits for the previous card, so the deck is always idle here
    assert property (@(posedge clk) disable iff (!rst)
        card_req |-> deck_ready);

endmodule

//--- blackjack_top.sv
// Seed is sampled when a game starts; shuffle length is fixed when the design is built
`timescale 1ns/10ps

module blackjack_top #(
    parameter int SHUFFLE_STEPS = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [5:0]       seed,
    input  logic             start,
    input  logic             hit,
    input  logic             stand,
    output logic             player_turn,
    output logic             game_done,
    output bj_pkg::outcome_e outcome,
    output bj_pkg::table_t   table_state
);

    // Deck handshake
    logic          shuffle_start;
    logic          card_req;
    logic          deck_ready;
    logic          card_valid;
    bj_pkg::card_t card;

    // Hand store control
    logic          add_card;
    logic          clear;
    bj_pkg::side_e side;

    card_deck #(
        .SHUFFLE_STEPS(SHUFFLE_STEPS)
    ) u_deck (
        .clk           (clk),
        .rst           (rst),
        .seed          (seed),
        .shuffle_start (shuffle_start),
        .card_req      (card_req),
        .deck_ready    (deck_ready),
        .card_valid    (card_valid),
        .card          (card)
    );

    hand_store u_hands (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .add_card    (add_card),
        .side        (side),
        .card        (card),
        .table_state (table_state)
    );

    game_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .hit           (hit),
        .stand         (stand),
        .deck_ready    (deck_ready),
        .card_valid    (card_valid),
        .table_state   (table_state),
        .shuffle_start (shuffle_start),
        .card_req      (card_req),
        .add_card      (add_card),
        .side          (side),
        .clear         (clear),
        .player_turn   (player_turn),
        .game_done     (game_done),
        .outcome       (outcome)
    );

endmodule

//--- tb_clock_gen.sv
// Free-running 4 ns clock; active-low reset is held for the first five rising edges
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Release just after an edge so no flop sees it change on the edge
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

//--- tb_blackjack.sv
// Random games from a fixed seed against a deck and rules model; SHUFFLE_STEPS must match the DUT
`timescale 1ns/10ps

module tb_blackjack;

    localparam int SHUFFLE_STEPS = 32;
    localparam int NUM_GAMES     = 40;
    localparam int WAIT_LIMIT    = 1000;
    localparam int DRIVE_DELAY   = 1;

    // What wait_until waits for
    localparam int WAIT_RESET = 0;
    localparam int WAIT_FIRST = 1;
    localparam int WAIT_MOVE  = 2;
    localparam int WAIT_LEFT  = 3;

    logic             clk;
    logic             rst;
    logic [5:0]       seed;
    logic             start;
    logic             hit;
    logic             stand;
    logic             player_turn;
    logic             game_done;
    bj_pkg::outcome_e outcome;
    bj_pkg::table_t   table_state;

    integer           rand_seed;
    logic [15:0]      model_lfsr;
    bj_pkg::table_t   exp_table;
    bj_pkg::outcome_e exp_outcome;
    bj_pkg::card_t    drawn;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    blackjack_top #(
        .SHUFFLE_STEPS(SHUFFLE_STEPS)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .seed        (seed),
        .start       (start),
        .hit         (hit),
        .stand       (stand),
        .player_turn (player_turn),
        .game_done   (game_done),
        .outcome     (outcome),
        .table_state (table_state)
    );

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_card(input bj_pkg::card_t got, input bj_pkg::card_t exp,
                                input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic compare_table(input bj_pkg::table_t got, input bj_pkg::table_t exp,
                                 input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_outcome(input bj_pkg::outcome_e got, input bj_pkg::outcome_e exp,
                                   input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0d ns: %s is %s, expected %s", $time, what,
                               got.name(), exp.name()));
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Sample and drive a little after each rising edge
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_until(input int kind, input string what);
        int n;
        n = 0;
        while (!((kind == WAIT_RESET && rst === 1'b1) ||
                 (kind == WAIT_FIRST && player_turn === 1'b1) ||
                 (kind == WAIT_MOVE && (player_turn === 1'b1 || game_done === 1'b1)) ||
                 (kind == WAIT_LEFT && player_turn === 1'b0))) begin
            if (n == WAIT_LIMIT) begin
                stop_run($sformatf("Timed out at %0d ns waiting for %s", $time, what));
            end
            next_cycle();
            n++;
        end
    endtask

    // Hold the button until the controller leaves the player turn
    task automatic press(input logic is_hit);
        hit   = is_hit;
        stand = !is_hit;
        wait_until(WAIT_LEFT, "the controller to take the move");
        hit   = 1'b0;
        stand = 1'b0;
    endtask

    function automatic bj_pkg::sum_t point_value(bj_pkg::card_t c);
        return (c >= 4'd10) ? 6'd10 : {2'b00, c};
    endfunction

    function automatic logic [15:0] next_lfsr(logic [15:0] x);
        return {x[14:0], x[15] ^ x[13] ^ x[12] ^ x[10]};
    endfunction

    // Step until the low nibble is a rank
    task automatic draw_card(output bj_pkg::card_t c);
        model_lfsr = next_lfsr(model_lfsr);
        while (model_lfsr[3:0] == 4'd0 || model_lfsr[3:0] > 4'd13) begin
            model_lfsr = next_lfsr(model_lfsr);
        end
        c = model_lfsr[3:0];
    endtask

    task automatic give_card(input bj_pkg::side_e s);
        bj_pkg::hand_t h;
        draw_card(drawn);
        h = (s == bj_pkg::SIDE_HOUSE) ? exp_table.house : exp_table.player;
        h.cards[h.count] = drawn;
        h.count          = h.count + 3'd1;
        h.sum            = h.sum + point_value(drawn);
        if (s == bj_pkg::SIDE_HOUSE) begin
            exp_table.house = h;
        end else begin
            exp_table.player = h;
        end
    endtask

    task automatic play_game(input int g);
        logic         more;
        bj_pkg::sum_t p;
        bj_pkg::sum_t h;
        // Every eighth game replays the previous seed
        if (g % 8 != 7) begin
            seed = 6'($random(rand_seed));
        end
        model_lfsr = {bj_pkg::LFSR_INIT[15:6], seed};
        repeat (SHUFFLE_STEPS) model_lfsr = next_lfsr(model_lfsr);
        exp_table = '0;
        for (int i = 0; i < 4; i++) begin
            give_card((i % 2 == 1) ? bj_pkg::SIDE_HOUSE : bj_pkg::SIDE_PLAYER);
        end
        start = 1'b1;
        wait_until(WAIT_FIRST, "the first player turn");
        start = 1'b0;
        compare_table(table_state, exp_table, "table after the deal");
        more = 1'b1;
        while (more) begin
            if (($random(rand_seed) & 3) != 0) begin
                press(1'b1);
                give_card(bj_pkg::SIDE_PLAYER);
                wait_until(WAIT_MOVE, "player turn or game end after a hit");
                compare_card(table_state.player.cards[exp_table.player.count - 3'd1], drawn,
                             "newest player card");
                more = (exp_table.player.sum <= bj_pkg::BUST_LIMIT) &&
                       (exp_table.player.count < bj_pkg::MAX_CARDS);
                compare_flag(player_turn, more, "player_turn after a hit");
                if (more) begin
                    compare_table(table_state, exp_table, "table after a hit");
                end
            end else begin
                press(1'b0);
                more = 1'b0;
            end
        end
        // House draws only against a live player hand
        if (exp_table.player.sum <= bj_pkg::BUST_LIMIT) begin
            while (exp_table.house.sum < bj_pkg::HOUSE_STAND &&
                   exp_table.house.count < bj_pkg::MAX_CARDS) begin
                give_card(bj_pkg::SIDE_HOUSE);
            end
        end
        p = exp_table.player.sum;
        h = exp_table.house.sum;
        if (p > bj_pkg::BUST_LIMIT) begin
            exp_outcome = bj_pkg::OUT_HOUSE_WIN;
        end else if (h > bj_pkg::BUST_LIMIT || p > h) begin
            exp_outcome = bj_pkg::OUT_PLAYER_WIN;
        end else if (h > p) begin
            exp_outcome = bj_pkg::OUT_HOUSE_WIN;
        end else begin
            exp_outcome = bj_pkg::OUT_DRAW;
        end
        wait_until(WAIT_MOVE, "the end of the game");
        compare_flag(game_done, 1'b1, "game_done at the end of the game");
        compare_table(table_state, exp_table, "final table");
        compare_outcome(outcome, exp_outcome, "outcome");
    endtask

    initial begin
        rand_seed = 32'hf063;
        seed      = '0;
        start     = 1'b0;
        hit       = 1'b0;
        stand     = 1'b0;
        wait_until(WAIT_RESET, "reset release");
        compare_flag(player_turn, 1'b0, "player_turn after reset");
        compare_flag(game_done, 1'b0, "game_done after reset");
        compare_outcome(outcome, bj_pkg::OUT_NONE, "outcome after reset");
        compare_table(table_state, bj_pkg::table_t'('0), "table after reset");
        for (int g = 0; g < NUM_GAMES; g++) begin
            play_game(g);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
bj_pkg.sv
card_deck.sv
hand_store.sv
game_fsm.sv
blackjack_top.sv
tb_clock_gen.sv
tb_blackjack.sv

//--- Bender.yml
package:
  name: blackjack

sources:
  - files:
      - bj_pkg.sv
      - card_deck.sv
      - hand_store.sv
      - game_fsm.sv
      - blackjack_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_blackjack.sv
